/* rtl/y86_settings.svh */
`ifndef Y86_SETTINGS_SVH
`define Y86_SETTINGS_SVH

// width of every Y86-64 data word
`define Y86_WORD_W 64

// cycles given to the ALU path
// any value of 1 or more works
`define Y86_EXEC_CYCLES 3

// condition codes after reset
`define Y86_CC_RESET_ZF 1'b1
`define Y86_CC_RESET_SF 1'b0
`define Y86_CC_RESET_OF 1'b0

`endif

/* rtl/y86Pkg.sv */
package y86Pkg;

	// Y86-64 instruction codes, as fetched from the high nibble
	typedef enum logic [3:0]
	{
		icHalt   = 4'h0,
		icNop    = 4'h1,
		// rrmovq and the cmovXX family share this code
		icRrmovq = 4'h2,
		icIrmovq = 4'h3,
		icRmmovq = 4'h4,
		icMrmovq = 4'h5,
		icOpq    = 4'h6,
		icJxx    = 4'h7,
		icCall   = 4'h8,
		icRet    = 4'h9,
		icPushq  = 4'hA,
		icPopq   = 4'hB
	} icode_t;

	// ALU functions, same order as the OPq ifun field
	typedef enum logic [1:0]
	{
		aluAdd = 2'd0,
		aluSub = 2'd1,
		aluAnd = 2'd2,
		aluXor = 2'd3
	} aluFun_t;

	// execute sequencing
	typedef enum logic [1:0]
	{
		// waiting for start
		stIdle   = 2'd0,
		// ALU path settling
		stExec   = 2'd1,
		// results captured this cycle
		stReport = 2'd2
	} execState_t;

endpackage

/* rtl/aluOperandSelect.sv */
`timescale 1ns/1ps
`include "y86_settings.svh"

module aluOperandSelect
(
	input  y86Pkg::icode_t          icode,
	input  logic [3:0]              ifun,
	input  logic [`Y86_WORD_W-1:0]  valA,
	input  logic [`Y86_WORD_W-1:0]  valB,
	input  logic [`Y86_WORD_W-1:0]  valC,
	output logic [`Y86_WORD_W-1:0]  aluA,
	output logic [`Y86_WORD_W-1:0]  aluB,
	output y86Pkg::aluFun_t         aluFun
);

	// one stack slot
	localparam logic [`Y86_WORD_W-1:0] stackStep = `Y86_WORD_W'(8);

	always_comb
	begin
		case (icode)
			y86Pkg::icRrmovq,
			y86Pkg::icOpq:
				aluA = valA;
			y86Pkg::icIrmovq,
			y86Pkg::icRmmovq,
			y86Pkg::icMrmovq:
				aluA = valC;
			// stack grows down
			y86Pkg::icCall,
			y86Pkg::icPushq:
				aluA = -stackStep;
			y86Pkg::icRet,
			y86Pkg::icPopq:
				aluA = stackStep;
			default:
				aluA = '0;
		endcase
	end

	always_comb
	begin
		case (icode)
			y86Pkg::icRmmovq,
			y86Pkg::icMrmovq,
			y86Pkg::icOpq,
			y86Pkg::icCall,
			y86Pkg::icRet,
			y86Pkg::icPushq,
			y86Pkg::icPopq:
				aluB = valB;
			// irmovq and rrmovq pass aluA through with a zero
			default:
				aluB = '0;
		endcase
	end

	// only OPq picks its own function
	always_comb
	begin
		if (icode == y86Pkg::icOpq)
			aluFun = y86Pkg::aluFun_t'(ifun[1:0]);
		else
			aluFun = y86Pkg::aluAdd;
	end

endmodule

/* rtl/y86Alu.sv */
`timescale 1ns/1ps
`include "y86_settings.svh"

module y86Alu
(
	input  logic [`Y86_WORD_W-1:0]  aluA,
	input  logic [`Y86_WORD_W-1:0]  aluB,
	input  y86Pkg::aluFun_t         aluFun,
	output logic [`Y86_WORD_W-1:0]  result,
	output logic                    flagZ,
	output logic                    flagS,
	output logic                    flagO
);

	localparam int Msb = `Y86_WORD_W - 1;

	logic [`Y86_WORD_W-1:0] sumOut;
	logic [`Y86_WORD_W-1:0] diffOut;
	logic                   addOvf;
	logic                   subOvf;

	// note the operand order: subq computes valB - valA
	assign sumOut  = aluB + aluA;
	assign diffOut = aluB - aluA;

	// same-sign operands, result sign flipped
	assign addOvf = (aluA[Msb] == aluB[Msb]) && (sumOut[Msb] != aluA[Msb]);

	// signs differ and the result left the sign of aluB
	assign subOvf = (aluA[Msb] != aluB[Msb]) && (diffOut[Msb] != aluB[Msb]);

	always_comb
	begin
		case (aluFun)
			y86Pkg::aluAdd:
			begin
				result = sumOut;
				flagO  = addOvf;
			end
			y86Pkg::aluSub:
			begin
				result = diffOut;
				flagO  = subOvf;
			end
			y86Pkg::aluAnd:
			begin
				result = aluA & aluB;
				flagO  = 1'b0;
			end
			y86Pkg::aluXor:
			begin
				result = aluA ^ aluB;
				flagO  = 1'b0;
			end
			default:
			begin
				result = '0;
				flagO  = 1'b0;
			end
		endcase
	end

	assign flagZ = (result == '0);
	assign flagS = result[Msb];

endmodule

/* rtl/condCodeUnit.sv */
`timescale 1ns/1ps
`include "y86_settings.svh"

module condCodeUnit
(
	input  logic            clk,
	input  logic            arstN,
	input  logic            capture,
	input  y86Pkg::icode_t  icode,
	input  logic [3:0]      ifun,
	input  logic            flagZ,
	input  logic            flagS,
	input  logic            flagO,
	output logic            cnd,
	output logic            zf,
	output logic            sf,
	output logic            of
);

	logic sfXorOf;
	logic cndNext;

	assign sfXorOf = sf ^ of;

	// evaluated on the codes held before this instruction
	always_comb
	begin
		case (ifun)
			// always
			4'h0: cndNext = 1'b1;
			// le
			4'h1: cndNext = sfXorOf | zf;
			// l
			4'h2: cndNext = sfXorOf;
			// e
			4'h3: cndNext = zf;
			// ne
			4'h4: cndNext = ~zf;
			// ge
			4'h5: cndNext = ~sfXorOf;
			// g
			4'h6: cndNext = ~sfXorOf & ~zf;
			default: cndNext = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			zf  <= `Y86_CC_RESET_ZF;
			sf  <= `Y86_CC_RESET_SF;
			of  <= `Y86_CC_RESET_OF;
			cnd <= 1'b0;
		end
		else if (capture)
		begin
			cnd <= cndNext;
			// only arithmetic and logic ops touch the codes
			if (icode == y86Pkg::icOpq)
			begin
				zf <= flagZ;
				sf <= flagS;
				of <= flagO;
			end
		end
	end

endmodule

/* rtl/execTimer.sv */
`timescale 1ns/1ps
`include "y86_settings.svh"

module execTimer
(
	input  logic clk,
	input  logic arstN,
	input  logic timerLoad,
	output logic timerExpired
);

	localparam int CntW = $clog2(`Y86_EXEC_CYCLES + 1);

	logic [CntW-1:0] count;

	// load with the budget, then run down to zero and stop
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			count <= '0;
		else if (timerLoad)
			count <= CntW'(`Y86_EXEC_CYCLES);
		else if (count != '0)
			count <= count - 1'b1;
	end

	// last cycle of the budget
	assign timerExpired = (count == CntW'(1));

endmodule

/* rtl/execControl.sv */
`timescale 1ns/1ps

module execControl
(
	input  logic clk,
	input  logic arstN,
	input  logic start,
	input  logic timerExpired,
	output logic timerLoad,
	output logic capture,
	output logic busy,
	output logic done
);

	y86Pkg::execState_t state;
	y86Pkg::execState_t stateNext;

	always_comb
	begin
		stateNext = state;
		case (state)
			y86Pkg::stIdle:
			begin
				if (start)
					stateNext = y86Pkg::stExec;
			end
			y86Pkg::stExec:
			begin
				if (timerExpired)
					stateNext = y86Pkg::stReport;
			end
			y86Pkg::stReport:
				stateNext = y86Pkg::stIdle;
			default:
				stateNext = y86Pkg::stIdle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			state <= y86Pkg::stIdle;
		else
			state <= stateNext;
	end

	// start only counts while idle
	assign timerLoad = (state == y86Pkg::stIdle) && start;
	assign capture   = (state == y86Pkg::stReport);
	assign busy      = (state != y86Pkg::stIdle);

	// done lands one cycle after capture
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			done <= 1'b0;
		else
			done <= capture;
	end

endmodule

/* rtl/executeStage.sv */
`timescale 1ns/1ps
`include "y86_settings.svh"

module executeStage
(
	input  logic                    clk,
	input  logic                    arstN,
	input  logic                    start,
	input  y86Pkg::icode_t          icode,
	input  logic [3:0]              ifun,
	input  logic [`Y86_WORD_W-1:0]  valA,
	input  logic [`Y86_WORD_W-1:0]  valB,
	input  logic [`Y86_WORD_W-1:0]  valC,
	output logic                    busy,
	output logic                    done,
	output logic [`Y86_WORD_W-1:0]  valE,
	output logic                    cnd,
	output logic                    zf,
	output logic                    sf,
	output logic                    of
);

	logic timerLoad;
	logic timerExpired;
	logic capture;

	y86Pkg::icode_t         icodeQ;
	logic [3:0]             ifunQ;
	logic [`Y86_WORD_W-1:0] valAQ;
	logic [`Y86_WORD_W-1:0] valBQ;
	logic [`Y86_WORD_W-1:0] valCQ;

	logic [`Y86_WORD_W-1:0] aluA;
	logic [`Y86_WORD_W-1:0] aluB;
	y86Pkg::aluFun_t        aluFun;
	logic [`Y86_WORD_W-1:0] aluResult;
	logic                   flagZ;
	logic                   flagS;
	logic                   flagO;

	// instruction latch, loaded when a start is accepted
	always_ff @(posedge clk)
	begin
		if (timerLoad)
		begin
			icodeQ <= icode;
			ifunQ  <= ifun;
			valAQ  <= valA;
			valBQ  <= valB;
			valCQ  <= valC;
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			valE <= '0;
		else if (capture)
			valE <= aluResult;
	end

	execControl execControl_i
	(
		.clk          (clk),
		.arstN        (arstN),
		.start        (start),
		.timerExpired (timerExpired),
		.timerLoad    (timerLoad),
		.capture      (capture),
		.busy         (busy),
		.done         (done)
	);

	execTimer execTimer_i
	(
		.clk          (clk),
		.arstN        (arstN),
		.timerLoad    (timerLoad),
		.timerExpired (timerExpired)
	);

	aluOperandSelect aluOperandSelect_i
	(
		.icode  (icodeQ),
		.ifun   (ifunQ),
		.valA   (valAQ),
		.valB   (valBQ),
		.valC   (valCQ),
		.aluA   (aluA),
		.aluB   (aluB),
		.aluFun (aluFun)
	);

	// multi-cycle path, sampled only on capture
	y86Alu y86Alu_i
	(
		.aluA   (aluA),
		.aluB   (aluB),
		.aluFun (aluFun),
		.result (aluResult),
		.flagZ  (flagZ),
		.flagS  (flagS),
		.flagO  (flagO)
	);

	condCodeUnit condCodeUnit_i
	(
		.clk     (clk),
		.arstN   (arstN),
		.capture (capture),
		.icode   (icodeQ),
		.ifun    (ifunQ),
		.flagZ   (flagZ),
		.flagS   (flagS),
		.flagO   (flagO),
		.cnd     (cnd),
		.zf      (zf),
		.sf      (sf),
		.of      (of)
	);

endmodule

/* sim/executeStage_tb.sv */
`timescale 1ns/1ps
`include "y86_settings.svh"

module executeStage_tb;

	localparam int W = `Y86_WORD_W;
	localparam int ExpectedLatency = `Y86_EXEC_CYCLES + 2;
	localparam int MaxInstr = 200;
	localparam int WatchdogCycles = 5 + MaxInstr * (`Y86_EXEC_CYCLES + 4) + 50;
	localparam logic [W-1:0] MinNeg = {1'b1, {(W-1){1'b0}}};
	localparam logic [W-1:0] MaxPos = {1'b0, {(W-1){1'b1}}};

	logic           clk;
	logic           arstN;
	logic           start;
	y86Pkg::icode_t icode;
	logic [3:0]     ifun;
	logic [W-1:0]   valA;
	logic [W-1:0]   valB;
	logic [W-1:0]   valC;
	logic           busy;
	logic           done;
	logic [W-1:0]   valE;
	logic           cnd;
	logic           zf;
	logic           sf;
	logic           of;

	logic [31:0]    lcgState = 32'h1941;
	// model condition codes as {zf, sf, of}
	logic [2:0]     ccModel;
	logic [W-1:0]   expValE[$];
	logic           expCnd[$];
	logic [2:0]     expCc[$];

	executeStage executeStage_i
	(
		.clk   (clk),
		.arstN (arstN),
		.start (start),
		.icode (icode),
		.ifun  (ifun),
		.valA  (valA),
		.valB  (valB),
		.valC  (valC),
		.busy  (busy),
		.done  (done),
		.valE  (valE),
		.cnd   (cnd),
		.zf    (zf),
		.sf    (sf),
		.of    (of)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	function automatic logic [W-1:0] randWord();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcgNext();
		lo = lcgNext();
		return {hi, lo};
	endfunction

	// expected valE, cnd and condition codes for one instruction
	function automatic void refExecute(input logic [3:0] ic, input logic [3:0] fn,
		input logic [W-1:0] a, input logic [W-1:0] b, input logic [W-1:0] c,
		input logic [2:0] ccIn, output logic [W-1:0] resE, output logic resCnd,
		output logic [2:0] ccOut);
		logic [W-1:0] opA;
		logic [W-1:0] opB;
		logic [W:0]   wide;
		logic         ovf;
		logic         sxo;
		opA = '0;
		opB = '0;
		ovf = 1'b0;
		case (ic)
			4'h2, 4'h6: opA = a;
			4'h3, 4'h4, 4'h5: opA = c;
			4'h8, 4'hA: opA = -W'(8);
			4'h9, 4'hB: opA = W'(8);
			default: opA = '0;
		endcase
		if (ic inside {4'h4, 4'h5, 4'h6, 4'h8, 4'h9, 4'hA, 4'hB})
			opB = b;
		if (ic == 4'h6 && fn[1:0] == 2'd1)
		begin
			// overflow when the top two bits of the sign-extended difference disagree
			wide = {opB[W-1], opB} - {opA[W-1], opA};
			resE = wide[W-1:0];
			ovf = wide[W] ^ wide[W-1];
		end
		else if (ic == 4'h6 && fn[1:0] == 2'd2)
			resE = opA & opB;
		else if (ic == 4'h6 && fn[1:0] == 2'd3)
			resE = opA ^ opB;
		else
		begin
			wide = {opB[W-1], opB} + {opA[W-1], opA};
			resE = wide[W-1:0];
			ovf = wide[W] ^ wide[W-1];
		end
		sxo = ccIn[1] ^ ccIn[0];
		case (fn)
			4'h0: resCnd = 1'b1;
			4'h1: resCnd = sxo | ccIn[2];
			4'h2: resCnd = sxo;
			4'h3: resCnd = ccIn[2];
			4'h4: resCnd = ~ccIn[2];
			4'h5: resCnd = ~sxo;
			4'h6: resCnd = ~sxo & ~ccIn[2];
			default: resCnd = 1'b0;
		endcase
		if (ic == 4'h6)
			ccOut = {(resE == '0), resE[W-1], ovf};
		else
			ccOut = ccIn;
	endfunction

	task automatic stopFailed();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on failure");
	endtask

	task automatic checkValue(input logic [W-1:0] got, input logic [W-1:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			stopFailed();
		end
	endtask

	// issue one instruction on a falling edge and follow it to done
	task automatic runInstr(input logic [3:0] ic, input logic [3:0] fn, input logic [W-1:0] a,
		input logic [W-1:0] b, input logic [W-1:0] c, input bit extraStart);
		logic [W-1:0] e;
		logic         cn;
		logic [2:0]   ccNew;
		int           cycles;
		refExecute(ic, fn, a, b, c, ccModel, e, cn, ccNew);
		expValE.push_back(e);
		expCnd.push_back(cn);
		expCc.push_back(ccNew);
		ccModel = ccNew;
		icode = y86Pkg::icode_t'(ic);
		ifun = fn;
		valA = a;
		valB = b;
		valC = c;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		cycles = 1;
		while (!done)
		begin
			checkValue(busy, 1'b1, "busy while executing");
			// a second start while busy must be dropped
			if (extraStart && cycles == 1)
			begin
				icode = y86Pkg::icOpq;
				ifun = 4'h1;
				valA = randWord();
				valB = randWord();
				start = 1'b1;
			end
			else
				start = 1'b0;
			@(negedge clk);
			cycles++;
		end
		start = 1'b0;
		checkValue(cycles, ExpectedLatency, "start to done latency in cycles");
		checkValue(busy, 1'b0, "busy on the done cycle");
	endtask

	// compares results on every done pulse
	always @(negedge clk)
	begin
		if (arstN && done)
		begin
			if (expValE.size() == 0)
			begin
				$display("done pulsed at %0t ns with no instruction outstanding", $time);
				stopFailed();
			end
			checkValue(valE, expValE.pop_front(), "valE");
			checkValue(cnd, expCnd.pop_front(), "cnd");
			checkValue({zf, sf, of}, expCc.pop_front(), "condition codes {zf,sf,of}");
		end
	end

	initial
	begin
		repeat (WatchdogCycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", WatchdogCycles);
		stopFailed();
	end

	initial
	begin
		logic [W-1:0] pa[6];
		logic [W-1:0] pb[6];
		logic [3:0]   pf[6];
		arstN = 1'b0;
		start = 1'b0;
		icode = y86Pkg::icNop;
		ifun = 4'h0;
		valA = '0;
		valB = '0;
		valC = '0;
		ccModel = {`Y86_CC_RESET_ZF, `Y86_CC_RESET_SF, `Y86_CC_RESET_OF};
		repeat (5) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);

		checkValue(busy, 1'b0, "busy after reset");
		checkValue(done, 1'b0, "done after reset");
		checkValue(valE, '0, "valE after reset");
		checkValue(cnd, 1'b0, "cnd after reset");
		checkValue({zf, sf, of}, ccModel, "condition codes after reset");

		// OPq with random and corner operands
		for (int i = 0; i < 40; i++)
			runInstr(4'h6, 4'(i % 4), randWord(), randWord(), randWord(), 1'b0);
		runInstr(4'h6, 4'h0, W'(1), MaxPos, '0, 1'b0);
		runInstr(4'h6, 4'h0, MinNeg, MinNeg, '0, 1'b0);
		runInstr(4'h6, 4'h1, W'(1), MinNeg, '0, 1'b0);
		runInstr(4'h6, 4'h1, '1, MaxPos, '0, 1'b0);
		runInstr(4'h6, 4'h1, MaxPos, MaxPos, '0, 1'b0);
		runInstr(4'h6, 4'h2, MinNeg, MaxPos, '0, 1'b0);
		runInstr(4'h6, 4'h3, MinNeg, MinNeg, '0, 1'b0);
		runInstr(4'h6, 4'h3, MaxPos, '1, '0, 1'b0);

		// moves, memory and stack ops leave the codes alone
		runInstr(4'h6, 4'h1, W'(9), W'(2), '0, 1'b0);
		for (int i = 0; i < 3; i++)
		begin
			runInstr(4'h2, 4'h0, randWord(), randWord(), randWord(), 1'b0);
			runInstr(4'h3, 4'h0, randWord(), randWord(), randWord(), 1'b0);
			runInstr(4'h4, 4'h0, randWord(), randWord(), randWord(), 1'b0);
			runInstr(4'h5, 4'h0, randWord(), randWord(), randWord(), 1'b0);
			runInstr(4'h8, 4'h0, randWord(), randWord(), randWord(), 1'b0);
			runInstr(4'h9, 4'h0, randWord(), randWord(), randWord(), 1'b0);
			runInstr(4'hA, 4'h0, randWord(), randWord(), randWord(), 1'b0);
			runInstr(4'hB, 4'h0, randWord(), randWord(), randWord(), 1'b0);
		end
		runInstr(4'h0, 4'h0, randWord(), randWord(), randWord(), 1'b0);
		runInstr(4'h1, 4'h0, randWord(), randWord(), randWord(), 1'b0);

		// each flag pattern followed by every condition for cmovXX and jXX
		pa = '{W'(5), W'(5), W'(1), W'(1), W'(1), MinNeg};
		pb = '{W'(5), W'(3), MaxPos, MinNeg, W'(2), MinNeg};
		pf = '{4'h1, 4'h1, 4'h0, 4'h1, 4'h0, 4'h0};
		for (int p = 0; p < 6; p++)
		begin
			runInstr(4'h6, pf[p], pa[p], pb[p], '0, 1'b0);
			for (int f = 0; f < 8; f++)
			begin
				runInstr(4'h2, 4'(f), randWord(), randWord(), randWord(), 1'b0);
				runInstr(4'h7, 4'(f), randWord(), randWord(), randWord(), 1'b0);
			end
		end

		// starts while busy
		runInstr(4'h6, 4'h0, randWord(), randWord(), '0, 1'b1);
		runInstr(4'h3, 4'h0, randWord(), randWord(), randWord(), 1'b1);

		// a stray done pulse here has no instruction left to match
		repeat (4) @(negedge clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* compile.f */
+incdir+rtl
rtl/y86Pkg.sv
rtl/aluOperandSelect.sv
rtl/y86Alu.sv
rtl/condCodeUnit.sv
rtl/execTimer.sv
rtl/execControl.sv
rtl/executeStage.sv
sim/executeStage_tb.sv
